// ==== build.f ====
logic/fetch_pkg.sv
logic/line_fill_if.sv
logic/line_fill.sv
logic/fetch_sequencer.sv
logic/inst_queue.sv
logic/fetch_front_end.sv
tb/bmem_model.sv
tb/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - logic/fetch_pkg.sv
  - logic/line_fill_if.sv
  - logic/line_fill.sv
  - logic/fetch_sequencer.sv
  - logic/inst_queue.sv
  - logic/fetch_front_end.sv
  - target: test
    files:
      - tb/bmem_model.sv
      - tb/fetch_tb.sv

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam int RUN_WORDS   = 64;
    localparam int GAP_WORDS   = 100;
    localparam int AFTER_WORDS = 24;
    localparam int TOTAL_DEQ   = RUN_WORDS + GAP_WORDS + 6 * AFTER_WORDS;
    localparam int CYCLE_LIMIT = 20 * TOTAL_DEQ + 2000;
    localparam int FULL_PAUSE  = 150;

    logic clk, rst;
    logic bmem_read_o, bmem_ready_i, bmem_rvalid_i;
    logic redirect_i, deq_i, empty_o;
    fetch_pkg::addr_t  bmem_addr_o, bmem_raddr_i, redirect_pc_i, inst_pc_o;
    fetch_pkg::beat_t  bmem_rdata_i;
    fetch_pkg::order_t redirect_order_i, inst_order_o;
    fetch_pkg::inst_t  inst_o;

    // reference stream and the head captured at each dequeue
    fetch_pkg::addr_t  exp_pc, seen_pc, last_read_addr;
    fetch_pkg::order_t exp_order, seen_order;
    fetch_pkg::inst_t  seen_inst;
    logic [31:0]       rnd;
    int                read_count;
    int                run_reads;
    int                cycles = 0;

    fetch_front_end fetch_front_end_inst (.*);

    bmem_model bmem_model_inst (
        .clk      (clk),
        .rst      (rst),
        .addr_i   (bmem_addr_o),
        .read_i   (bmem_read_o),
        .ready_o  (bmem_ready_i),
        .raddr_o  (bmem_raddr_i),
        .rdata_o  (bmem_rdata_i),
        .rvalid_o (bmem_rvalid_i)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t a);
        return a ^ 32'h5A5A_0000;
    endfunction

    function automatic fetch_pkg::addr_t line_base(input fetch_pkg::addr_t a);
        return {a[31:fetch_pkg::LINE_OFFSET_BITS], {fetch_pkg::LINE_OFFSET_BITS{1'b0}}};
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_inst(input fetch_pkg::inst_t got, input fetch_pkg::inst_t want,
                              input string name);
        if (got !== want)
            fail_stop($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, want));
    endtask

    task automatic check_pc(input fetch_pkg::addr_t got, input fetch_pkg::addr_t want,
                            input string name);
        if (got !== want)
            fail_stop($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, want));
    endtask

    task automatic check_order(input fetch_pkg::order_t got, input fetch_pkg::order_t want,
                               input string name);
        if (got !== want)
            fail_stop($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, want));
    endtask

    task automatic check_flag(input logic got, input logic want, input string name);
        if (got !== want)
            fail_stop($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, want));
    endtask

    task automatic check_count(input int got, input int want, input string name);
        if (got != want)
            fail_stop($sformatf("FAIL %0t %s got %0d expected %0d", $time, name, got, want));
    endtask

    task automatic pop_head;
        seen_inst  = inst_o;
        seen_pc    = inst_pc_o;
        seen_order = inst_order_o;
        deq_i      = 1'b1;
        @(negedge clk);
        deq_i = 1'b0;
    endtask

    task automatic consume(input int n, input int max_gap);
        int gap;
        for (int i = 0; i < n; i++) begin
            rnd = xorshift(rnd);
            gap = int'(rnd % 32'(max_gap + 1));
            repeat (gap) @(negedge clk);
            while (empty_o) @(negedge clk);
            pop_head();
        end
    endtask

    task automatic apply_redirect(input fetch_pkg::addr_t pc, input fetch_pkg::order_t ord);
        redirect_i       = 1'b1;
        redirect_pc_i    = pc;
        redirect_order_i = ord;
        @(negedge clk);
        redirect_i = 1'b0;
        check_flag(empty_o, 1'b1, "empty_o");
    endtask

    // queue is full, so the buffer holds the line of the newest entry
    task automatic redirect_in_line;
        fetch_pkg::addr_t newest;
        newest = exp_pc + 32'(4 * (fetch_pkg::QUEUE_DEPTH - 1));
        rnd    = xorshift(rnd);
        apply_redirect(line_base(newest) + {27'd0, rnd[2:0], 2'b00}, {rnd, ~rnd});
    endtask

    task automatic redirect_far(input fetch_pkg::addr_t base);
        rnd = xorshift(rnd);
        apply_redirect(base + {20'd0, rnd[11:2], 2'b00}, {~rnd, rnd});
    endtask

    // keeps draining until a new burst read goes out
    task automatic wait_for_read;
        int start;
        start = read_count;
        while (read_count == start) begin
            if (!empty_o) pop_head();
            else @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) fail_stop("timeout, the run did not finish in its cycle limit");
    end

    always @(posedge clk) begin
        if (rst) begin
            read_count <= 0;
            run_reads  <= 0;
        end else if (bmem_read_o) begin
            check_pc(bmem_addr_o, line_base(bmem_addr_o), "bmem_addr_o");
            read_count     <= read_count + 1;
            last_read_addr <= bmem_addr_o;
            if (bmem_addr_o >= fetch_pkg::RESET_PC &&
                bmem_addr_o < fetch_pkg::RESET_PC + 32'(RUN_WORDS * 4))
                run_reads <= run_reads + 1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_pc    = fetch_pkg::RESET_PC;
            exp_order = '0;
        end else if (redirect_i) begin
            exp_pc    = redirect_pc_i;
            exp_order = redirect_order_i;
        end else if (deq_i) begin
            check_inst(seen_inst, mem_word(exp_pc), "inst_o");
            check_pc(seen_pc, exp_pc, "inst_pc_o");
            check_order(seen_order, exp_order, "inst_order_o");
            exp_pc    = exp_pc + 32'd4;
            exp_order = exp_order + 64'd1;
        end
    end

    initial begin
        int               reads_before;
        fetch_pkg::addr_t next_line;
        rst              = 1'b1;
        deq_i            = 1'b0;
        redirect_i       = 1'b0;
        redirect_pc_i    = '0;
        redirect_order_i = '0;
        rnd              = 32'd27672;
        repeat (4) @(negedge clk);
        check_flag(bmem_read_o, 1'b0, "bmem_read_o");
        check_flag(empty_o, 1'b1, "empty_o");
        rst = 1'b0;
        @(negedge clk);
        check_flag(bmem_read_o, 1'b0, "bmem_read_o");
        check_flag(empty_o, 1'b1, "empty_o");

        consume(RUN_WORDS, 0);
        check_count(run_reads, RUN_WORDS * 4 / (1 << fetch_pkg::LINE_OFFSET_BITS), "line reads");
        consume(GAP_WORDS, 30);

        // hit in the buffered line shows up one cycle after the flush
        repeat (FULL_PAUSE) @(negedge clk);
        reads_before = read_count;
        redirect_in_line();
        @(negedge clk);
        check_flag(empty_o, 1'b0, "empty_o");
        // first read after the redirect fetches the following line
        next_line = line_base(exp_pc) + 32'(1 << fetch_pkg::LINE_OFFSET_BITS);
        while (read_count == reads_before) @(negedge clk);
        check_pc(last_read_addr, next_line, "bmem_addr_o");
        consume(AFTER_WORDS, 3);

        // second redirect lands on the cycle of the first hit
        repeat (FULL_PAUSE) @(negedge clk);
        redirect_in_line();
        redirect_far(32'h0000_8000);
        consume(AFTER_WORDS, 2);

        repeat (FULL_PAUSE) @(negedge clk);
        redirect_far(32'h0002_0000);
        consume(AFTER_WORDS, 2);

        // fill outstanding when the redirect arrives
        wait_for_read();
        redirect_far(32'h0004_0000);
        consume(AFTER_WORDS, 1);
        wait_for_read();
        redirect_far(32'h0006_0000);
        consume(AFTER_WORDS, 1);
        wait_for_read();
        rnd = xorshift(rnd);
        apply_redirect(last_read_addr + {27'd0, rnd[2:0], 2'b00}, {rnd, rnd});
        consume(AFTER_WORDS, 1);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/bmem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module bmem_model (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire fetch_pkg::addr_t  addr_i,
    input  wire logic              read_i,
    output      logic              ready_o,
    output      fetch_pkg::addr_t  raddr_o,
    output      fetch_pkg::beat_t  rdata_o,
    output      logic              rvalid_o
);

    fetch_pkg::addr_t req_addr;
    logic [31:0]      rnd;
    int               reads_seen;
    int               reads_served;
    int               beat;
    int               gap;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic fetch_pkg::inst_t stored_word(input fetch_pkg::addr_t a);
        return a ^ 32'h5A5A_0000;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            reads_seen <= 0;
        end else if (read_i) begin
            reads_seen <= reads_seen + 1;
            req_addr   <= addr_i;
        end
    end

    // beats and ready change on the falling edge, gaps of up to three cycles
    initial begin
        rnd          = 32'd27672;
        ready_o      = 1'b0;
        raddr_o      = '0;
        rdata_o      = '0;
        rvalid_o     = 1'b0;
        reads_served = 0;
        beat         = 0;
        gap          = 0;
        forever begin
            @(negedge clk);
            rnd      = xorshift(rnd);
            rvalid_o = 1'b0;
            if (rst) begin
                ready_o      = 1'b0;
                reads_served = 0;
                beat         = 0;
                gap          = 0;
            end else if (gap > 0) begin
                gap     = gap - 1;
                ready_o = 1'b0;
            end else if (reads_served != reads_seen) begin
                ready_o  = 1'b0;
                rvalid_o = 1'b1;
                raddr_o  = req_addr;
                rdata_o  = {stored_word(req_addr + 32'(8 * beat + 4)),
                            stored_word(req_addr + 32'(8 * beat))};
                gap      = int'(rnd[1:0]);
                beat     = beat + 1;
                if (beat == fetch_pkg::BEATS_PER_LINE) begin
                    beat         = 0;
                    reads_served = reads_served + 1;
                end
            end else if (!ready_o) begin
                ready_o = 1'b1;
            end else if (rnd[4:2] == 3'd0) begin
                ready_o = 1'b0;
                gap     = int'(rnd[1:0]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_front_end (
    input  wire logic               clk,
    input  wire logic               rst,

    output      fetch_pkg::addr_t   bmem_addr_o,
    output      logic               bmem_read_o,
    input  wire logic               bmem_ready_i,
    input  wire fetch_pkg::addr_t   bmem_raddr_i,
    input  wire fetch_pkg::beat_t   bmem_rdata_i,
    input  wire logic               bmem_rvalid_i,

    input  wire logic               redirect_i,
    input  wire fetch_pkg::addr_t   redirect_pc_i,
    input  wire fetch_pkg::order_t  redirect_order_i,

    input  wire logic               deq_i,
    output      logic               empty_o,
    output      fetch_pkg::inst_t   inst_o,
    output      fetch_pkg::addr_t   inst_pc_o,
    output      fetch_pkg::order_t  inst_order_o
);

    line_fill_if fill_bus ();

    // sequencer to queue
    logic               enq;
    fetch_pkg::inst_t   enq_inst;
    fetch_pkg::addr_t   enq_pc;
    fetch_pkg::order_t  enq_order;
    logic               full;

    line_fill line_fill_inst (
        .clk           (clk),
        .rst           (rst),
        .fill          (fill_bus.filler),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    fetch_sequencer fetch_sequencer_inst (
        .clk              (clk),
        .rst              (rst),
        .fill             (fill_bus.requester),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .redirect_order_i (redirect_order_i),
        .full_i           (full),
        .enq_o            (enq),
        .enq_inst_o       (enq_inst),
        .enq_pc_o         (enq_pc),
        .enq_order_o      (enq_order)
    );

    // redirect empties the queue
    inst_queue inst_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_i),
        .enq_i        (enq),
        .enq_inst_i   (enq_inst),
        .enq_pc_i     (enq_pc),
        .enq_order_i  (enq_order),
        .deq_i        (deq_i),
        .full_o       (full),
        .empty_o      (empty_o),
        .head_inst_o  (inst_o),
        .head_pc_o    (inst_pc_o),
        .head_order_o (inst_order_o)
    );

endmodule

`default_nettype wire

// ==== logic/inst_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_queue (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               flush_i,

    input  wire logic               enq_i,
    input  wire fetch_pkg::inst_t   enq_inst_i,
    input  wire fetch_pkg::addr_t   enq_pc_i,
    input  wire fetch_pkg::order_t  enq_order_i,

    input  wire logic               deq_i,
    output      logic               full_o,
    output      logic               empty_o,
    output      fetch_pkg::inst_t   head_inst_o,
    output      fetch_pkg::addr_t   head_pc_o,
    output      fetch_pkg::order_t  head_order_o
);

    fetch_pkg::inst_t  inst_mem  [fetch_pkg::QUEUE_DEPTH];
    fetch_pkg::addr_t  pc_mem    [fetch_pkg::QUEUE_DEPTH];
    fetch_pkg::order_t order_mem [fetch_pkg::QUEUE_DEPTH];

    logic [$clog2(fetch_pkg::QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(fetch_pkg::QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(fetch_pkg::QUEUE_DEPTH+1)-1:0] count;
    logic                                        do_enq;
    logic                                        do_deq;

    assign full_o  = (count == fetch_pkg::QUEUE_DEPTH);
    assign empty_o = (count == '0);
    assign do_enq  = enq_i && !full_o;
    assign do_deq  = deq_i && !empty_o;

    // head shown straight from storage
    assign head_inst_o  = inst_mem[rd_ptr];
    assign head_pc_o    = pc_mem[rd_ptr];
    assign head_order_o = order_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (do_deq && !do_enq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            inst_mem[wr_ptr]  <= enq_inst_i;
            pc_mem[wr_ptr]    <= enq_pc_i;
            order_mem[wr_ptr] <= enq_order_i;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        deq_i |-> !empty_o);

    assert property (@(posedge clk) disable iff (rst)
        enq_i |-> !full_o);

endmodule

`default_nettype wire

// ==== logic/fetch_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer (
    input  wire logic               clk,
    input  wire logic               rst,

    line_fill_if.requester          fill,

    input  wire logic               redirect_i,
    input  wire fetch_pkg::addr_t   redirect_pc_i,
    input  wire fetch_pkg::order_t  redirect_order_i,

    input  wire logic               full_i,
    output      logic               enq_o,
    output      fetch_pkg::inst_t   enq_inst_o,
    output      fetch_pkg::addr_t   enq_pc_o,
    output      fetch_pkg::order_t  enq_order_o
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::addr_t        pc;
    fetch_pkg::order_t       order;

    // single line buffer
    fetch_pkg::line_t        buf_line;
    fetch_pkg::addr_t        buf_addr;
    logic                    buf_valid;

    fetch_pkg::addr_t        fill_addr;
    fetch_pkg::addr_t        line_base;
    fetch_pkg::word_idx_t    word_sel;
    logic                    hit;
    logic                    start_fill;

    assign line_base = {pc[31:fetch_pkg::LINE_OFFSET_BITS],
                        {fetch_pkg::LINE_OFFSET_BITS{1'b0}}};
    assign word_sel  = pc[fetch_pkg::LINE_OFFSET_BITS-1:2];

    assign hit = buf_valid &&
                 (buf_addr[31:fetch_pkg::LINE_OFFSET_BITS] ==
                  pc[31:fetch_pkg::LINE_OFFSET_BITS]);

    // redirect beats a hit in the same cycle
    assign enq_o      = (state == fetch_pkg::FETCH_RUN) && hit && !full_i && !redirect_i;
    assign start_fill = (state == fetch_pkg::FETCH_RUN) && !hit && !full_i && !redirect_i;

    assign enq_inst_o  = buf_line[32'(word_sel) * 32 +: 32];
    assign enq_pc_o    = pc;
    assign enq_order_o = order;

    assign fill.req       = (state == fetch_pkg::FETCH_WAIT);
    assign fill.line_addr = fill_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= fetch_pkg::FETCH_RUN;
            pc        <= fetch_pkg::RESET_PC;
            order     <= '0;
            buf_valid <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc    <= redirect_pc_i;
                order <= redirect_order_i;
            end else if (enq_o) begin
                pc    <= pc + 32'd4;
                order <= order + 64'd1;
            end

            case (state)
                fetch_pkg::FETCH_RUN: begin
                    if (start_fill) begin
                        state <= fetch_pkg::FETCH_WAIT;
                    end
                end
                fetch_pkg::FETCH_WAIT: begin
                    // a redirect here leaves the fill running
                    if (fill.done) begin
                        state     <= fetch_pkg::FETCH_RUN;
                        buf_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= fetch_pkg::FETCH_RUN;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            fill_addr <= line_base;
        end
        if (fill.done) begin
            buf_line <= fill.line;
            buf_addr <= fill_addr;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        enq_o |-> !full_i);

    // done only ever answers an outstanding request
    assert property (@(posedge clk) disable iff (rst)
        fill.done |-> state == fetch_pkg::FETCH_WAIT);

endmodule

`default_nettype wire

// ==== logic/line_fill.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fill (
    input  wire logic              clk,
    input  wire logic              rst,

    line_fill_if.filler            fill,

    output      fetch_pkg::addr_t  bmem_addr_o,
    output      logic              bmem_read_o,
    input  wire logic              bmem_ready_i,
    input  wire fetch_pkg::addr_t  bmem_raddr_i,
    input  wire fetch_pkg::beat_t  bmem_rdata_i,
    input  wire logic              bmem_rvalid_i
);

    fetch_pkg::fill_state_t state;
    fetch_pkg::beat_idx_t   beat_cnt;
    fetch_pkg::line_t       line_q;
    logic                   last_beat;

    assign last_beat = bmem_rvalid_i &&
                       (beat_cnt == fetch_pkg::beat_idx_t'(fetch_pkg::BEATS_PER_LINE - 1));

    // one read pulse, held back while memory is busy
    assign bmem_read_o = (state == fetch_pkg::FILL_ISSUE) && bmem_ready_i;
    assign bmem_addr_o = fill.line_addr;

    assign fill.done = (state == fetch_pkg::FILL_DONE);
    assign fill.line = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fetch_pkg::FILL_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                fetch_pkg::FILL_IDLE: begin
                    beat_cnt <= '0;
                    if (fill.req && bmem_ready_i) begin
                        state <= fetch_pkg::FILL_ISSUE;
                    end
                end
                fetch_pkg::FILL_ISSUE: begin
                    if (bmem_ready_i) begin
                        state <= fetch_pkg::FILL_COLLECT;
                    end
                end
                fetch_pkg::FILL_COLLECT: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state <= fetch_pkg::FILL_DONE;
                    end
                end
                fetch_pkg::FILL_DONE: begin
                    state <= fetch_pkg::FILL_IDLE;
                end
                default: begin
                    state <= fetch_pkg::FILL_IDLE;
                end
            endcase
        end
    end

    // beat 0 lands in the low 64 bits
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::FILL_COLLECT && bmem_rvalid_i) begin
            line_q[32'(beat_cnt) * 64 +: 64] <= bmem_rdata_i;
        end
    end

    // every beat belongs to the line the sequencer asked for
    assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> bmem_raddr_i == fill.line_addr);

    // no stray beats once the fill is over
    assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> state != fetch_pkg::FILL_IDLE);

endmodule

`default_nettype wire

// ==== logic/line_fill_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface line_fill_if;

    // req is held until done, line_addr stays put meanwhile
    logic              req;
    fetch_pkg::addr_t  line_addr;
    logic              done;
    fetch_pkg::line_t  line;

    modport requester (
        output req,
        output line_addr,
        input  done,
        input  line
    );

    modport filler (
        input  req,
        input  line_addr,
        output done,
        output line
    );

endinterface

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // address and data widths
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  inst_t;
    typedef logic [63:0]  order_t;
    typedef logic [63:0]  beat_t;
    typedef logic [255:0] line_t;

    // index within a line
    typedef logic [1:0] beat_idx_t;
    typedef logic [2:0] word_idx_t;

    localparam int    BEATS_PER_LINE   = 4;
    localparam int    LINE_OFFSET_BITS = 5;
    localparam addr_t RESET_PC         = 32'h0000_1000;
    localparam int    QUEUE_DEPTH      = 16;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ISSUE,
        FILL_COLLECT,
        FILL_DONE
    } fill_state_t;

    typedef enum logic {
        FETCH_RUN,
        FETCH_WAIT
    } fetch_state_t;

endpackage

`default_nettype wire
